// ==== src/rom_map_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// download-side types, index codes and chip-select codes of the loader
////////////////////////////////////////////////////////////////////////////

package rom_map_pkg;

    // host download port
    typedef logic [15:0] ioctl_index_t;
    typedef logic [26:0] ioctl_addr_t;
    typedef logic [7:0]  byte_t;

    // sdram program port
    typedef logic [15:0] sdram_word_t;
    typedef logic [1:0]  sdram_bank_t;

    // active-low selects: sound, bg tiles, fg tiles, sequencer, gray lut
    typedef logic [4:0]  bram_cs_t;

    localparam ioctl_index_t IDX_ROM   = 16'd0;
    localparam ioctl_index_t IDX_DIPSW = 16'd254;

    localparam int SDRAM_ADDR_W_DEF = 22;
    localparam int BRAM_ADDR_W_DEF  = 17;

    // byte address bit 17 picks the sdram bank and splits bg tiles off
    localparam int ADDR_BANK_BIT = 17;

    localparam bram_cs_t CS_NONE  = 5'b11111;
    localparam bram_cs_t CS_SOUND = 5'b01111;
    localparam bram_cs_t CS_TMBG  = 5'b10111;
    localparam bram_cs_t CS_TMFG  = 5'b11011;
    localparam bram_cs_t CS_SEQ   = 5'b11101;
    localparam bram_cs_t CS_GRAY  = 5'b11110;

    typedef enum logic {
        pk_idle,
        pk_busy
    } pack_state_t;

endpackage

// ==== src/board_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// board-side types, joystick bit positions and dip switch defaults
////////////////////////////////////////////////////////////////////////////

package board_cfg_pkg;

    typedef logic [15:0] joy_t;
    typedef logic [7:0]  btn_t;
    typedef logic [7:0]  dipsw_t;

    // host joystick word layout
    localparam int JOY_RIGHT   = 0;
    localparam int JOY_LEFT    = 1;
    localparam int JOY_DOWN    = 2;
    localparam int JOY_UP      = 3;
    localparam int JOY_ATTACK  = 4;
    localparam int JOY_JUMP    = 5;
    localparam int JOY_TEST    = 6;
    localparam int JOY_SERVICE = 7;
    localparam int JOY_COIN    = 8;
    localparam int JOY_START   = 9;

    // switch 1: 3 lives, demo sound on, upright, normal, no flip
    localparam dipsw_t DIPSW1_DEF = 8'hEF;
    // switch 2: 1 coin 1 play on both slots, invincibility off
    localparam dipsw_t DIPSW2_DEF = 8'hFF;

endpackage

// ==== src/ioctl_region_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// download decoder, sorts each host byte into sdram, bram or dip region
////////////////////////////////////////////////////////////////////////////

module ioctl_region_decode #(
    parameter int BRAM_ADDR_W = rom_map_pkg::BRAM_ADDR_W_DEF
) (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_EMU_INITRST,
    input  logic                     i_download_done,
    input  rom_map_pkg::ioctl_index_t i_ioctl_index,
    input  rom_map_pkg::ioctl_addr_t  i_ioctl_addr,
    input  logic                     i_ioctl_wr,
    input  logic                     i_packer_busy,
    output logic                     o_sdram_en,
    output logic                     o_bram_en,
    output logic                     o_dipsw_en,
    output logic                     o_sdram_wr_stb,
    output logic                     o_bram_wr_stb,
    output logic                     o_dipsw_wr_stb
);
    import rom_map_pkg::*;

    // the bram window sits just above the bank bit
    localparam int SEL_BIT = BRAM_ADDR_W + 1;

    logic rom_idx;
    logic sdram_hit;
    logic bram_hit;
    logic dipsw_hit;

    assign rom_idx   = (i_ioctl_index == IDX_ROM);
    assign sdram_hit = rom_idx & ~i_ioctl_addr[SEL_BIT];
    assign bram_hit  = rom_idx & i_ioctl_addr[SEL_BIT];
    // only switch bytes 0 and 1 exist
    assign dipsw_hit = (i_ioctl_index == IDX_DIPSW) && (i_ioctl_addr[26:1] == '0);

    // strobes follow the current byte, sdram side held off while packing
    assign o_sdram_wr_stb = i_ioctl_wr & sdram_hit & ~i_packer_busy & ~i_download_done;
    assign o_bram_wr_stb  = i_ioctl_wr & bram_hit & ~i_download_done;
    assign o_dipsw_wr_stb = i_ioctl_wr & dipsw_hit & ~i_download_done;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || i_download_done) begin
            o_sdram_en <= 1'b0;
            o_bram_en  <= 1'b0;
            o_dipsw_en <= 1'b0;
        end else begin
            o_sdram_en <= sdram_hit;
            o_bram_en  <= bram_hit;
            o_dipsw_en <= dipsw_hit;
        end
    end

    // the monitor counts on a single active region at any time
    a_one_region: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        $onehot0({o_sdram_en, o_bram_en, o_dipsw_en}));

endmodule

// ==== src/control_mapper.sv ====
////////////////////////////////////////////////////////////////////////////
// joystick mapper, host words to active-low board button bytes
////////////////////////////////////////////////////////////////////////////

module control_mapper (
    input  board_cfg_pkg::joy_t i_joystick0,
    input  board_cfg_pkg::joy_t i_joystick1,
    output board_cfg_pkg::btn_t o_sys_btn,
    output board_cfg_pkg::btn_t o_p1_btn,
    output board_cfg_pkg::btn_t o_p2_btn
);
    import board_cfg_pkg::*;

    // system byte, bits 2 and 3 unused on the board
    assign o_sys_btn[0] = ~i_joystick0[JOY_START];
    assign o_sys_btn[1] = ~i_joystick1[JOY_START];
    assign o_sys_btn[2] = 1'b1;
    assign o_sys_btn[3] = 1'b1;
    assign o_sys_btn[4] = ~i_joystick0[JOY_TEST];
    assign o_sys_btn[5] = ~i_joystick0[JOY_SERVICE];
    assign o_sys_btn[6] = ~i_joystick0[JOY_COIN];
    assign o_sys_btn[7] = ~i_joystick1[JOY_COIN];

    // player 1, jump below attack
    assign o_p1_btn[0] = ~i_joystick0[JOY_RIGHT];
    assign o_p1_btn[1] = ~i_joystick0[JOY_LEFT];
    assign o_p1_btn[2] = ~i_joystick0[JOY_DOWN];
    assign o_p1_btn[3] = ~i_joystick0[JOY_UP];
    assign o_p1_btn[4] = ~i_joystick0[JOY_JUMP];
    assign o_p1_btn[5] = ~i_joystick0[JOY_ATTACK];
    assign o_p1_btn[7:6] = 2'b11;

    // player 2 (cocktail), attack and jump swapped
    assign o_p2_btn[0] = ~i_joystick1[JOY_RIGHT];
    assign o_p2_btn[1] = ~i_joystick1[JOY_LEFT];
    assign o_p2_btn[2] = ~i_joystick1[JOY_DOWN];
    assign o_p2_btn[3] = ~i_joystick1[JOY_UP];
    assign o_p2_btn[4] = ~i_joystick1[JOY_ATTACK];
    assign o_p2_btn[5] = ~i_joystick1[JOY_JUMP];
    assign o_p2_btn[7:6] = 2'b11;

endmodule

// ==== src/sdram_word_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// sdram word packer, byte pairs to 16-bit program writes with ack wait
////////////////////////////////////////////////////////////////////////////

module sdram_word_packer #(
    parameter int SDRAM_ADDR_W = rom_map_pkg::SDRAM_ADDR_W_DEF
) (
    input  logic                      i_EMU_MCLK,
    input  logic                      i_EMU_INITRST,
    input  logic                      i_download_done,
    input  logic                      i_wr_stb,
    input  rom_map_pkg::ioctl_addr_t  i_ioctl_addr,
    input  rom_map_pkg::byte_t        i_ioctl_data,
    input  logic                      i_sdram_init,
    input  logic                      i_sdram_prog_ack,
    output logic                      o_busy,
    output logic                      o_ioctl_wait,
    output logic                      o_sdram_prog_wr,
    output logic [SDRAM_ADDR_W-1:0]   o_sdram_prog_addr,
    output rom_map_pkg::sdram_bank_t  o_sdram_prog_ba,
    output rom_map_pkg::sdram_word_t  o_sdram_prog_data
);
    import rom_map_pkg::*;

    pack_state_t state;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || i_download_done) begin
            state <= pk_idle;
        end else if (state == pk_idle) begin
            if (i_wr_stb && i_ioctl_addr[0]) begin
                state <= pk_busy;
            end
        end else if (i_sdram_prog_ack) begin
            state <= pk_idle;
        end
    end

    // even byte is the upper half, odd byte completes the word
    always_ff @(posedge i_EMU_MCLK) begin
        if (state == pk_idle && i_wr_stb) begin
            if (!i_ioctl_addr[0]) begin
                o_sdram_prog_data[15:8] <= i_ioctl_data;
            end else begin
                o_sdram_prog_data[7:0] <= i_ioctl_data;
                o_sdram_prog_addr      <= SDRAM_ADDR_W'(i_ioctl_addr[16:1]);
                o_sdram_prog_ba        <= {1'b0, i_ioctl_addr[ADDR_BANK_BIT]};
            end
        end
    end

    assign o_busy          = (state == pk_busy);
    assign o_sdram_prog_wr = o_busy;
    assign o_ioctl_wait    = o_busy | i_sdram_init;

    // request must not drop before the controller takes it
    a_req_hold: assert property (@(posedge i_EMU_MCLK)
        disable iff (i_EMU_INITRST || i_download_done)
        o_sdram_prog_wr && !i_sdram_prog_ack |=> o_sdram_prog_wr);

endmodule

// ==== src/bram_rom_writer.sv ====
////////////////////////////////////////////////////////////////////////////
// on-chip rom writer, registers each byte with its decoded chip select
////////////////////////////////////////////////////////////////////////////

module bram_rom_writer #(
    parameter int BRAM_ADDR_W = rom_map_pkg::BRAM_ADDR_W_DEF
) (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_EMU_INITRST,
    input  logic                     i_download_done,
    input  logic                     i_wr_stb,
    input  rom_map_pkg::ioctl_addr_t i_ioctl_addr,
    input  rom_map_pkg::byte_t       i_ioctl_data,
    output logic [BRAM_ADDR_W-1:0]   o_bram_addr,
    output rom_map_pkg::byte_t       o_bram_data,
    output logic                     o_bram_wr_n,
    output rom_map_pkg::bram_cs_t    o_bram_cs_n
);
    import rom_map_pkg::*;

    bram_cs_t cs_sel;

    // bank bit low is all background tiles, the rest splits on 16..15
    always_comb begin
        cs_sel = CS_NONE;
        if (!i_ioctl_addr[ADDR_BANK_BIT]) begin
            cs_sel = CS_TMBG;
        end else begin
            case (i_ioctl_addr[16:15])
                2'b00: cs_sel = CS_TMFG;
                2'b01: cs_sel = CS_SOUND;
                2'b10: begin
                    if (!i_ioctl_addr[10]) begin
                        cs_sel = CS_SEQ;
                    end else if (i_ioctl_addr[10:9] == 2'b10) begin
                        cs_sel = CS_GRAY;
                    end
                end
                default: cs_sel = CS_NONE;
            endcase
        end
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || i_download_done) begin
            o_bram_wr_n <= 1'b1;
            o_bram_cs_n <= CS_NONE;
        end else begin
            o_bram_wr_n <= ~i_wr_stb;
            if (i_wr_stb) begin
                o_bram_cs_n <= cs_sel;
            end
        end
    end

    // address and data need no clear, wr_n qualifies them
    always_ff @(posedge i_EMU_MCLK) begin
        if (i_wr_stb) begin
            o_bram_addr <= i_ioctl_addr[BRAM_ADDR_W-1:0];
            o_bram_data <= i_ioctl_data;
        end
    end

    // a write strobe with low wr_n must land in at most one rom
    a_one_cs: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        !o_bram_wr_n |-> $countones(~o_bram_cs_n) <= 1);

endmodule

// ==== src/dipsw_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// dip switch bank, two bytes loaded from the host download
////////////////////////////////////////////////////////////////////////////

module dipsw_bank (
    input  logic                  i_EMU_MCLK,
    input  logic                  i_EMU_INITRST,
    input  logic                  i_wr_stb,
    input  logic                  i_addr_lsb,
    input  rom_map_pkg::byte_t    i_ioctl_data,
    output board_cfg_pkg::dipsw_t o_dipsw1,
    output board_cfg_pkg::dipsw_t o_dipsw2
);
    import board_cfg_pkg::*;

    // values stay put after the download finishes
    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            o_dipsw1 <= DIPSW1_DEF;
            o_dipsw2 <= DIPSW2_DEF;
        end else if (i_wr_stb) begin
            if (!i_addr_lsb) begin
                o_dipsw1 <= i_ioctl_data;
            end else begin
                o_dipsw2 <= i_ioctl_data;
            end
        end
    end

endmodule

// ==== src/download_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// download monitor, raises done once every region was entered and left
////////////////////////////////////////////////////////////////////////////

module download_monitor (
    input  logic i_EMU_MCLK,
    input  logic i_EMU_INITRST,
    input  logic i_sdram_en,
    input  logic i_bram_en,
    input  logic i_dipsw_en,
    output logic o_download_done
);
    // bit order is sdram, bram, dip in every vector
    logic [2:0] en_now;
    logic [2:0] en_dly;
    logic [2:0] left_flags;
    logic [2:0] fall;

    assign en_now = {i_sdram_en, i_bram_en, i_dipsw_en};
    assign fall   = en_dly & ~en_now;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            en_dly          <= 3'b000;
            left_flags      <= 3'b000;
            o_download_done <= 1'b0;
        end else begin
            en_dly          <= en_now;
            // a region counts once it has been left
            left_flags      <= left_flags | fall;
            o_download_done <= &left_flags;
        end
    end

endmodule

// ==== src/rom_loader_top.sv ====
////////////////////////////////////////////////////////////////////////////
// rom loader top, host download routing and joystick mapping
////////////////////////////////////////////////////////////////////////////

module rom_loader_top #(
    parameter int SDRAM_ADDR_W = rom_map_pkg::SDRAM_ADDR_W_DEF,
    parameter int BRAM_ADDR_W  = rom_map_pkg::BRAM_ADDR_W_DEF
) (
    input  logic                      i_EMU_MCLK,
    input  logic                      i_EMU_INITRST,
    // host download port
    input  rom_map_pkg::ioctl_index_t i_ioctl_index,
    input  rom_map_pkg::ioctl_addr_t  i_ioctl_addr,
    input  rom_map_pkg::byte_t        i_ioctl_data,
    input  logic                      i_ioctl_wr,
    output logic                      o_ioctl_wait,
    // sdram program port
    input  logic                      i_sdram_init,
    input  logic                      i_sdram_prog_ack,
    output logic                      o_sdram_prog_en,
    output logic                      o_sdram_prog_wr,
    output logic [SDRAM_ADDR_W-1:0]   o_sdram_prog_addr,
    output rom_map_pkg::sdram_bank_t  o_sdram_prog_ba,
    output rom_map_pkg::sdram_word_t  o_sdram_prog_data,
    // on-chip rom port
    output logic [BRAM_ADDR_W-1:0]    o_bram_addr,
    output rom_map_pkg::byte_t        o_bram_data,
    output logic                      o_bram_wr_n,
    output rom_map_pkg::bram_cs_t     o_bram_cs_n,
    output board_cfg_pkg::dipsw_t     o_dipsw1,
    output board_cfg_pkg::dipsw_t     o_dipsw2,
    output logic                      o_download_done,
    // controls
    input  board_cfg_pkg::joy_t       i_joystick0,
    input  board_cfg_pkg::joy_t       i_joystick1,
    output board_cfg_pkg::btn_t       o_sys_btn,
    output board_cfg_pkg::btn_t       o_p1_btn,
    output board_cfg_pkg::btn_t       o_p2_btn
);
    logic bram_en;
    logic dipsw_en;
    logic sdram_wr_stb;
    logic bram_wr_stb;
    logic dipsw_wr_stb;
    logic packer_busy;

    ////////////////////////////////////////////////////////////////////////////
    // input side

    ioctl_region_decode #(.BRAM_ADDR_W(BRAM_ADDR_W)) u_decode (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .i_download_done (o_download_done),
        .i_ioctl_index   (i_ioctl_index),
        .i_ioctl_addr    (i_ioctl_addr),
        .i_ioctl_wr      (i_ioctl_wr),
        .i_packer_busy   (packer_busy),
        .o_sdram_en      (o_sdram_prog_en),
        .o_bram_en       (bram_en),
        .o_dipsw_en      (dipsw_en),
        .o_sdram_wr_stb  (sdram_wr_stb),
        .o_bram_wr_stb   (bram_wr_stb),
        .o_dipsw_wr_stb  (dipsw_wr_stb)
    );

    control_mapper u_ctrl (
        .i_joystick0 (i_joystick0),
        .i_joystick1 (i_joystick1),
        .o_sys_btn   (o_sys_btn),
        .o_p1_btn    (o_p1_btn),
        .o_p2_btn    (o_p2_btn)
    );

    ////////////////////////////////////////////////////////////////////////////
    // targets

    sdram_word_packer #(.SDRAM_ADDR_W(SDRAM_ADDR_W)) u_packer (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .i_EMU_INITRST     (i_EMU_INITRST),
        .i_download_done   (o_download_done),
        .i_wr_stb          (sdram_wr_stb),
        .i_ioctl_addr      (i_ioctl_addr),
        .i_ioctl_data      (i_ioctl_data),
        .i_sdram_init      (i_sdram_init),
        .i_sdram_prog_ack  (i_sdram_prog_ack),
        .o_busy            (packer_busy),
        .o_ioctl_wait      (o_ioctl_wait),
        .o_sdram_prog_wr   (o_sdram_prog_wr),
        .o_sdram_prog_addr (o_sdram_prog_addr),
        .o_sdram_prog_ba   (o_sdram_prog_ba),
        .o_sdram_prog_data (o_sdram_prog_data)
    );

    bram_rom_writer #(.BRAM_ADDR_W(BRAM_ADDR_W)) u_bram (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .i_download_done (o_download_done),
        .i_wr_stb        (bram_wr_stb),
        .i_ioctl_addr    (i_ioctl_addr),
        .i_ioctl_data    (i_ioctl_data),
        .o_bram_addr     (o_bram_addr),
        .o_bram_data     (o_bram_data),
        .o_bram_wr_n     (o_bram_wr_n),
        .o_bram_cs_n     (o_bram_cs_n)
    );

    dipsw_bank u_dipsw (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .i_wr_stb      (dipsw_wr_stb),
        .i_addr_lsb    (i_ioctl_addr[0]),
        .i_ioctl_data  (i_ioctl_data),
        .o_dipsw1      (o_dipsw1),
        .o_dipsw2      (o_dipsw2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output side

    download_monitor u_monitor (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .i_sdram_en      (o_sdram_prog_en),
        .i_bram_en       (bram_en),
        .i_dipsw_en      (dipsw_en),
        .o_download_done (o_download_done)
    );

endmodule

// ==== tests/rom_loader_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// rom loader testbench, replays the case file against the loader top
////////////////////////////////////////////////////////////////////////////

module rom_loader_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string CASE_FILE = "tests/loader_cases.txt";

    // characters seen by the case file reader
    localparam int CH_W    = 87;
    localparam int CH_J    = 74;
    localparam int CH_D    = 68;
    localparam int CH_F    = 70;
    localparam int CH_HASH = 35;
    localparam int CH_NL   = 10;

    logic        mclk;
    logic        initrst;
    logic [15:0] ioctl_index;
    logic [26:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        ioctl_wait;
    logic        sdram_init;
    logic        sdram_prog_ack;
    logic        sdram_prog_en;
    logic        sdram_prog_wr;
    logic [21:0] sdram_prog_addr;
    logic [1:0]  sdram_prog_ba;
    logic [15:0] sdram_prog_data;
    logic [16:0] bram_addr;
    logic [7:0]  bram_data;
    logic        bram_wr_n;
    logic [4:0]  bram_cs_n;
    logic [7:0]  dipsw1;
    logic [7:0]  dipsw2;
    logic        download_done;
    logic [15:0] joystick0;
    logic [15:0] joystick1;
    logic [7:0]  sys_btn;
    logic [7:0]  p1_btn;
    logic [7:0]  p2_btn;

    int cycle_count  = 0;
    int cycle_limit  = 0;
    int case_err     = 0;
    int cases_run    = 0;
    int cases_failed = 0;
    // loader is expected frozen once a done case has been seen
    bit frozen       = 1'b0;

    rom_loader_top #(
        .SDRAM_ADDR_W (22),
        .BRAM_ADDR_W  (17)
    ) UUT (
        .i_EMU_MCLK        (mclk),
        .i_EMU_INITRST     (initrst),
        .i_ioctl_index     (ioctl_index),
        .i_ioctl_addr      (ioctl_addr),
        .i_ioctl_data      (ioctl_data),
        .i_ioctl_wr        (ioctl_wr),
        .o_ioctl_wait      (ioctl_wait),
        .i_sdram_init      (sdram_init),
        .i_sdram_prog_ack  (sdram_prog_ack),
        .o_sdram_prog_en   (sdram_prog_en),
        .o_sdram_prog_wr   (sdram_prog_wr),
        .o_sdram_prog_addr (sdram_prog_addr),
        .o_sdram_prog_ba   (sdram_prog_ba),
        .o_sdram_prog_data (sdram_prog_data),
        .o_bram_addr       (bram_addr),
        .o_bram_data       (bram_data),
        .o_bram_wr_n       (bram_wr_n),
        .o_bram_cs_n       (bram_cs_n),
        .o_dipsw1          (dipsw1),
        .o_dipsw2          (dipsw2),
        .o_download_done   (download_done),
        .i_joystick0       (joystick0),
        .i_joystick1       (joystick1),
        .o_sys_btn         (sys_btn),
        .o_p1_btn          (p1_btn),
        .o_p2_btn          (p2_btn)
    );

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    always @(posedge mclk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge mclk);
        end
        $display("Timeout: no result after %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sdram controller model that acks each request after 1 to 8 cycles

    initial begin : ack_model
        int delay;
        sdram_prog_ack = 1'b0;
        void'($urandom(34234));
        forever begin
            @(negedge mclk);
            if (sdram_prog_wr === 1'b1) begin
                delay = int'($urandom_range(8, 1));
                repeat (delay) @(posedge mclk);
                sdram_prog_ack <= 1'b1;
                @(posedge mclk);
                sdram_prog_ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and reporting

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            case_err++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Error at %0t ns: %s", $time, what);
            case_err++;
        end
    endtask

    task automatic close_case(input string label);
        cases_run++;
        if (case_err == 0) begin
            $display("case %0d %s: pass", cases_run, label);
        end else begin
            cases_failed++;
            $display("case %0d %s: %0d error(s)", cases_run, label, case_err);
        end
        case_err = 0;
    endtask

    function automatic logic is_op_letter(input int ch);
        return (ch == CH_W) || (ch == CH_J) || (ch == CH_D) || (ch == CH_F);
    endfunction

    task automatic count_cases(output int n);
        int fd;
        int ch;
        logic line_start;
        n = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            line_start = 1'b1;
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (line_start && is_op_letter(ch)) begin
                    n++;
                end
                line_start = (ch == CH_NL);
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // case operations that start and end at a falling edge

    task automatic write_byte(input logic [15:0] idx, input logic [26:0] a,
                              input logic [7:0] d, input logic [31:0] e1,
                              input logic [31:0] e2);
        int guard;
        logic is_rom;
        logic got_ack;
        guard = 0;
        while (ioctl_wait === 1'b1 && guard < 20) begin
            @(negedge mclk);
            guard++;
        end
        expect_true(ioctl_wait === 1'b0, "o_ioctl_wait stayed high before a write");
        @(posedge mclk);
        ioctl_index <= idx;
        ioctl_addr  <= a;
        ioctl_data  <= d;
        ioctl_wr    <= 1'b1;
        @(posedge mclk);
        ioctl_wr <= 1'b0;
        @(negedge mclk);
        is_rom = (idx == 16'h0000);
        if (!frozen) begin
            // sdram region enable follows index 0 with bit 18 low
            compare_value("o_sdram_prog_en", 32'(sdram_prog_en), 32'(is_rom && !a[18]));
        end
        if (frozen) begin
            compare_value("o_bram_wr_n", 32'(bram_wr_n), 32'd1);
            compare_value("o_bram_cs_n", 32'(bram_cs_n), 32'h1F);
            compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd0);
            compare_value("o_sdram_prog_en", 32'(sdram_prog_en), 32'd0);
        end else if (is_rom && a[18]) begin
            // on-chip rom port is valid for one cycle
            compare_value("o_bram_wr_n", 32'(bram_wr_n), 32'd0);
            compare_value("o_bram_cs_n", 32'(bram_cs_n), 32'(e1[4:0]));
            compare_value("o_bram_addr", 32'(bram_addr), 32'(a[16:0]));
            compare_value("o_bram_data", 32'(bram_data), 32'(d));
            @(negedge mclk);
            compare_value("o_bram_wr_n", 32'(bram_wr_n), 32'd1);
        end else if (is_rom && a[0]) begin
            compare_value("o_sdram_prog_data", 32'(sdram_prog_data), 32'(e1[15:0]));
            compare_value("o_sdram_prog_addr", 32'(sdram_prog_addr), 32'(a[16:1]));
            compare_value("o_sdram_prog_ba", 32'(sdram_prog_ba), 32'(e2[1:0]));
            guard = 0;
            got_ack = 1'b0;
            // request and wait hold through the cycle that takes the ack
            while (!got_ack && guard < 20) begin
                compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd1);
                compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd1);
                got_ack = sdram_prog_ack;
                @(negedge mclk);
                guard++;
            end
            expect_true(got_ack, "no SDRAM ack arrived within 20 cycles");
            compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd0);
            compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd0);
        end else begin
            // no request for an upper sdram byte or a dip byte
            compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd0);
            compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd0);
        end
    endtask

    task automatic drive_joysticks(input logic [15:0] j0, input logic [15:0] j1,
                                   input logic [7:0] sys, input logic [7:0] p1,
                                   input logic [7:0] p2);
        @(posedge mclk);
        joystick0 <= j0;
        joystick1 <= j1;
        @(negedge mclk);
        compare_value("o_sys_btn", 32'(sys_btn), 32'(sys));
        compare_value("o_p1_btn", 32'(p1_btn), 32'(p1));
        compare_value("o_p2_btn", 32'(p2_btn), 32'(p2));
    endtask

    task automatic check_done(input logic exp);
        int guard;
        guard = 0;
        if (exp) begin
            while (download_done !== 1'b1 && guard < 4) begin
                @(negedge mclk);
                guard++;
            end
            // one cycle for the loader to see done
            @(negedge mclk);
            // loader back in its reset state
            compare_value("o_bram_wr_n", 32'(bram_wr_n), 32'd1);
            compare_value("o_bram_cs_n", 32'(bram_cs_n), 32'h1F);
            compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd0);
            compare_value("o_sdram_prog_en", 32'(sdram_prog_en), 32'd0);
            frozen = 1'b1;
        end
        compare_value("o_download_done", 32'(download_done), 32'(exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int fd;
        int ch;
        int n;
        int n_cases;
        logic at_eof;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        initrst     = 1'b1;
        ioctl_index = 16'hFFFF;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        sdram_init  = 1'b0;
        joystick0   = '0;
        joystick1   = '0;
        count_cases(n_cases);
        cycle_limit = n_cases * 12 + 100;
        repeat (5) @(posedge mclk);
        initrst <= 1'b0;
        @(negedge mclk);

        compare_value("o_download_done", 32'(download_done), 32'd0);
        compare_value("o_bram_wr_n", 32'(bram_wr_n), 32'd1);
        compare_value("o_bram_cs_n", 32'(bram_cs_n), 32'h1F);
        compare_value("o_sdram_prog_wr", 32'(sdram_prog_wr), 32'd0);
        compare_value("o_sdram_prog_en", 32'(sdram_prog_en), 32'd0);
        close_case("reset");

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Error: case file %s could not be opened", CASE_FILE);
            cases_failed++;
        end else begin
            at_eof = 1'b0;
            while (!at_eof) begin
                ch = $fgetc(fd);
                if (ch == -1) begin
                    at_eof = 1'b1;
                end else if (ch == CH_HASH) begin
                    while (ch != CH_NL && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                    at_eof = (ch == -1);
                end else if (ch == CH_W) begin
                    n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    expect_true(n == 5, "malformed write line in the case file");
                    write_byte(f0[15:0], f1[26:0], f2[7:0], f3, f4);
                    close_case("write");
                end else if (ch == CH_J) begin
                    n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    expect_true(n == 5, "malformed joystick line in the case file");
                    drive_joysticks(f0[15:0], f1[15:0], f2[7:0], f3[7:0], f4[7:0]);
                    close_case("joystick");
                end else if (ch == CH_D) begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    expect_true(n == 2, "malformed dip switch line in the case file");
                    compare_value("o_dipsw1", 32'(dipsw1), 32'(f0[7:0]));
                    compare_value("o_dipsw2", 32'(dipsw2), 32'(f1[7:0]));
                    close_case("dipsw");
                end else if (ch == CH_F) begin
                    n = $fscanf(fd, "%h", f0);
                    expect_true(n == 1, "malformed done line in the case file");
                    check_done(f0[0]);
                    close_case("done");
                end
            end
            $fclose(fd);
        end

        $display("%0d cases run, %0d passed, %0d failed",
                 cases_run, cases_run - cases_failed, cases_failed);
        if (cases_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
src/rom_map_pkg.sv
src/board_cfg_pkg.sv
src/ioctl_region_decode.sv
src/control_mapper.sv
src/sdram_word_packer.sv
src/bram_rom_writer.sv
src/dipsw_bank.sv
src/download_monitor.sv
src/rom_loader_top.sv
tests/rom_loader_tb.sv

// ==== Makefile ====
# Verilator build and run for the ROM loader testbench

.PHONY: all lint clean

all: obj_dir/Vrom_loader_tb
	./obj_dir/Vrom_loader_tb | tee sim.log
	grep -q "TEST OK" sim.log

obj_dir/Vrom_loader_tb: compile.f $(wildcard src/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module rom_loader_tb -f compile.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module rom_loader_top -f compile.f

clean:
	rm -rf obj_dir sim.log

// ==== tests/loader_cases.txt ====
# W index addr data cs_or_word bank | J joy0 joy1 sys p1 p2 | D dipsw1 dipsw2 | F done
# unused W fields are 0, all W fields are ignored once done is expected
F 0
D EF FF
J 0000 0000 FF FF FF
J 0010 0010 FF DF EF
J 0020 0020 FF EF DF
J 03C5 030A 0C FA F5
W 0000 41234 11 17 0
W 0000 60ABC 22 1B 0
W 0000 68123 33 0F 0
W 0000 70155 44 1D 0
W 0000 70456 55 1E 0
W 0000 78010 66 1F 0
W 0000 00246 A5 0 0
W 0000 00247 3C A53C 0
W 0000 2ACE0 5A 0 0
W 0000 2ACE1 C3 5AC3 1
F 0
W 00FE 0 3C 0 0
W 00FE 1 81 0 0
D 3C 81
W 00FE 2 99 0 0
D 3C 81
F 1
W 0000 41234 77 17 0
W 0000 00246 11 0 0
W 0000 00247 22 1122 0
W 00FE 0 00 0 0
D 3C 81
F 1
J FFFF FFFF 0C C0 C0
